/* bru_pkg.sv */
// ----------------------------------------
// branch resolution unit package
// widths, vector types, op codes and
// the payload structs between stages
// ----------------------------------------

package bru_pkg;

    localparam int XLEN            = 32;
    localparam int IMM20_WIDTH     = 20;
    localparam int ROB_INDEX_WIDTH = 7;
    localparam int PR_WIDTH        = 7;

    typedef logic [XLEN-1:0]            word_t;
    typedef logic [XLEN-1:0]            pc_t;
    typedef logic [IMM20_WIDTH-1:0]     imm20_t;
    typedef logic [PR_WIDTH-1:0]        pr_t;
    typedef logic [ROB_INDEX_WIDTH-1:0] rob_index_t;

    // op codes as sent by the issue queue
    typedef enum logic [3:0] {
        OP_JALR   = 4'd0,
        OP_C_JALR = 4'd1,
        OP_JAL    = 4'd2,
        OP_C_JAL  = 4'd3,
        OP_C_J    = 4'd4,
        OP_C_JR   = 4'd5,
        OP_LUI    = 4'd6,
        OP_AUIPC  = 4'd7,
        OP_BEQ    = 4'd8,
        OP_BNE    = 4'd9,
        OP_C_BEQZ = 4'd10,
        OP_C_BNEZ = 4'd11,
        OP_BLT    = 4'd12,
        OP_BGE    = 4'd13,
        OP_BLTU   = 4'd14,
        OP_BGEU   = 4'd15
    } bru_op_e;

    // ----------------------------------------
    // stage payloads

    typedef struct packed {
        bru_op_e    op;
        pc_t        pc;
        pc_t        pred_pc;
        imm20_t     imm20;      // compressed imm, sign always in bit 11
        word_t      a;
        word_t      b;
        pr_t        dest_pr;
        rob_index_t rob_index;
    } bru_issue_t;

    typedef struct packed {
        bru_op_e    op;
        pc_t        pc;
        pc_t        pred_pc;
        word_t      imm32;      // expanded imm
        word_t      a;
        word_t      b;
        pr_t        dest_pr;
        rob_index_t rob_index;
    } bru_ex_t;

    typedef struct packed {
        logic taken;
        pc_t  target_pc;
    } bru_target_t;

    typedef struct packed {
        pc_t   start_pc;
        word_t write_data;
    } bru_link_t;

    // ----------------------------------------
    // output interfaces

    typedef struct packed {
        word_t      data;
        pr_t        pr;
        rob_index_t rob_index;
    } bru_wb_t;

    typedef struct packed {
        rob_index_t rob_index;
        logic       is_mispredict;
        logic       is_taken;
        pc_t        start_pc;
        pc_t        target_pc;
    } bru_notif_t;

endpackage

/* bru_decode_stage.sv */
// ----------------------------------------
// issue register, imm20 expansion and
// execute register with hold logic
// ----------------------------------------

`timescale 1ns/1ps

module bru_decode_stage (
    input  logic                CLK,
    input  logic                nRST,
    input  logic                issue_valid,
    input  bru_pkg::bru_issue_t issue,
    output logic                issue_ready,
    input  logic                stall,
    output logic                ex_valid,
    output bru_pkg::bru_ex_t    ex
);

    import bru_pkg::*;

    logic       is_valid;   // issue register occupied
    bru_issue_t is_op;
    logic       ex_hold;
    logic       is_hold;
    word_t      imm32;
    bru_ex_t    next_ex;

    // ----------------------------------------
    // stall chain, bubbles never hold

    assign ex_hold     = ex_valid & stall;
    assign is_hold     = is_valid & ex_hold;
    assign issue_ready = ~is_hold;

    // ----------------------------------------
    // imm20 -> imm32 by op class

    always_comb begin
        case (is_op.op)
            // I-imm
            OP_JALR: begin
                imm32 = {{20{is_op.imm20[11]}}, is_op.imm20[11:0]};
            end
            // U-imm, sign bit lands in bit 31
            OP_LUI, OP_AUIPC: begin
                imm32 = {is_op.imm20[11:0], is_op.imm20[19:12], 12'h000};
            end
            // B-imm
            OP_BEQ, OP_BNE, OP_C_BEQZ, OP_C_BNEZ,
            OP_BLT, OP_BGE, OP_BLTU, OP_BGEU: begin
                imm32 = {{20{is_op.imm20[11]}}, is_op.imm20[0],
                         is_op.imm20[10:1], 1'b0};
            end
            // J-imm for remaining jumps
            default: begin
                imm32 = {{12{is_op.imm20[11]}}, is_op.imm20[19:12],
                         is_op.imm20[0], is_op.imm20[10:1], 1'b0};
            end
        endcase
    end

    always_comb begin
        next_ex.op        = is_op.op;
        next_ex.pc        = is_op.pc;
        next_ex.pred_pc   = is_op.pred_pc;
        next_ex.imm32     = imm32;
        next_ex.a         = is_op.a;
        next_ex.b         = is_op.b;
        next_ex.dest_pr   = is_op.dest_pr;
        next_ex.rob_index = is_op.rob_index;
    end

    // ----------------------------------------
    // registers

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            is_valid <= 1'b0;
            ex_valid <= 1'b0;
        end else begin
            if (issue_ready) begin
                is_valid <= issue_valid;
            end
            if (!ex_hold) begin
                ex_valid <= is_valid;
            end
        end
    end

    // payload follows the same enables
    always_ff @(posedge CLK) begin
        if (issue_ready) begin
            is_op <= issue;
        end
        if (!ex_hold) begin
            ex <= next_ex;
        end
    end

endmodule

/* bru_target_unit.sv */
// ----------------------------------------
// branch compare and target selection
// ----------------------------------------

`timescale 1ns/1ps

module bru_target_unit (
    input  bru_pkg::bru_ex_t     ex,
    output bru_pkg::bru_target_t tgt
);

    import bru_pkg::*;

    pc_t  pc_plus_imm;
    pc_t  pc_plus_4;
    pc_t  a_plus_imm;
    logic a_eq_b;
    logic a_eq_zero;
    logic a_lts_b;
    logic a_ltu_b;
    logic cond;         // branch condition holds

    assign pc_plus_imm = ex.pc + ex.imm32;
    assign pc_plus_4   = ex.pc + 32'd4;
    assign a_plus_imm  = ex.a + ex.imm32;

    assign a_eq_b    = ex.a == ex.b;
    assign a_eq_zero = ex.a == '0;
    assign a_lts_b   = $signed(ex.a) < $signed(ex.b);
    assign a_ltu_b   = ex.a < ex.b;

    // condition per conditional branch
    always_comb begin
        case (ex.op)
            OP_BEQ:    cond = a_eq_b;
            OP_BNE:    cond = ~a_eq_b;
            OP_C_BEQZ: cond = a_eq_zero;
            OP_C_BNEZ: cond = ~a_eq_zero;
            OP_BLT:    cond = a_lts_b;
            OP_BGE:    cond = ~a_lts_b;
            OP_BLTU:   cond = a_ltu_b;
            OP_BGEU:   cond = ~a_ltu_b;
            default:   cond = 1'b0;    // not a branch
        endcase
    end

    always_comb begin
        case (ex.op)
            OP_JALR: begin
                tgt.taken     = 1'b1;
                tgt.target_pc = a_plus_imm;
            end
            OP_C_JALR, OP_C_JR: begin
                tgt.taken     = 1'b1;
                tgt.target_pc = ex.a;       // register target, no offset
            end
            OP_JAL, OP_C_JAL, OP_C_J: begin
                tgt.taken     = 1'b1;
                tgt.target_pc = pc_plus_imm;
            end
            OP_LUI, OP_AUIPC: begin
                tgt.taken     = 1'b0;       // no notif sent anyway
                tgt.target_pc = pc_plus_imm;
            end
            default: begin
                tgt.taken     = cond;
                tgt.target_pc = cond ? pc_plus_imm : pc_plus_4;
            end
        endcase
    end

endmodule

/* bru_link_unit.sv */
// ----------------------------------------
// start pc and write data selection
// ----------------------------------------

`timescale 1ns/1ps

module bru_link_unit (
    input  bru_pkg::bru_ex_t   ex,
    output bru_pkg::bru_link_t link
);

    import bru_pkg::*;

    pc_t pc_plus_2;
    pc_t pc_plus_4;
    pc_t pc_plus_imm;

    assign pc_plus_2   = ex.pc + 32'd2;
    assign pc_plus_4   = ex.pc + 32'd4;
    assign pc_plus_imm = ex.pc + ex.imm32;

    // 16-bit ops start at their own pc, 32-bit ops at the upper half
    always_comb begin
        case (ex.op)
            OP_C_JALR, OP_C_JAL, OP_C_J,
            OP_C_JR, OP_C_BEQZ, OP_C_BNEZ: begin
                link.start_pc = ex.pc;
            end
            default: begin
                link.start_pc = pc_plus_2;
            end
        endcase
    end

    always_comb begin
        case (ex.op)
            OP_C_JALR, OP_C_JAL: link.write_data = pc_plus_2;
            OP_LUI:              link.write_data = ex.imm32;
            OP_AUIPC:            link.write_data = pc_plus_imm;
            // JALR, JAL link, rest don't care
            default:             link.write_data = pc_plus_4;
        endcase
    end

endmodule

/* bru_result_stage.sv */
// ----------------------------------------
// result register, output valids,
// mispredict flag and stall generation
// ----------------------------------------

`timescale 1ns/1ps

module bru_result_stage (
    input  logic                 CLK,
    input  logic                 nRST,
    input  logic                 ex_valid,
    input  bru_pkg::bru_ex_t     ex,
    input  bru_pkg::bru_target_t tgt,
    input  bru_pkg::bru_link_t   link,
    input  logic                 wb_ready,
    input  logic                 notif_ready,
    output logic                 stall,
    output logic                 wb_valid,
    output bru_pkg::bru_wb_t     wb,
    output logic                 notif_valid,
    output bru_pkg::bru_notif_t  notif
);

    import bru_pkg::*;

    logic        res_valid;
    bru_op_e     res_op;
    pr_t         res_dest_pr;
    rob_index_t  res_rob_index;
    pc_t         res_pred_pc;
    bru_target_t res_tgt;
    bru_link_t   res_link;
    logic        wb_op;     // op writes a register
    logic        notif_op;  // op notifies the rob

    // whole result waits until both sinks are free
    assign stall = (wb_valid & ~wb_ready) | (notif_valid & ~notif_ready);

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            res_valid <= 1'b0;
        end else if (!stall) begin
            res_valid <= ex_valid;
        end
    end

    always_ff @(posedge CLK) begin
        if (!stall) begin
            res_op        <= ex.op;
            res_dest_pr   <= ex.dest_pr;
            res_rob_index <= ex.rob_index;
            res_pred_pc   <= ex.pred_pc;
            res_tgt       <= tgt;
            res_link      <= link;
        end
    end

    // ----------------------------------------
    // output decode

    always_comb begin
        case (res_op)
            OP_JALR, OP_C_JALR, OP_JAL, OP_C_JAL: begin
                wb_op    = 1'b1;
                notif_op = 1'b1;
            end
            OP_LUI, OP_AUIPC: begin
                wb_op    = 1'b1;
                notif_op = 1'b0;
            end
            default: begin      // C_J, C_JR and conditional branches
                wb_op    = 1'b0;
                notif_op = 1'b1;
            end
        endcase
    end

    assign wb_valid    = res_valid & wb_op;
    assign notif_valid = res_valid & notif_op;

    always_comb begin
        wb.data         = res_link.write_data;
        wb.pr           = res_dest_pr;
        wb.rob_index    = res_rob_index;

        notif.rob_index     = res_rob_index;
        notif.is_mispredict = res_tgt.target_pc != res_pred_pc;
        notif.is_taken      = res_tgt.taken;
        notif.start_pc      = res_link.start_pc;
        notif.target_pc     = res_tgt.target_pc;
    end

endmodule

/* bru_pipeline.sv */
// ----------------------------------------
// branch resolution pipeline top level
// ----------------------------------------

`timescale 1ns/1ps

module bru_pipeline (
    input  logic                CLK,
    input  logic                nRST,
    input  logic                issue_valid,
    input  bru_pkg::bru_issue_t issue,
    output logic                issue_ready,
    output logic                wb_valid,
    output bru_pkg::bru_wb_t    wb,
    input  logic                wb_ready,
    output logic                notif_valid,
    output bru_pkg::bru_notif_t notif,
    input  logic                notif_ready
);

    import bru_pkg::*;

    logic        ex_valid;
    bru_ex_t     ex;
    bru_target_t tgt;
    bru_link_t   link;
    logic        stall;     // result stage holding

    bru_decode_stage u_decode (
        .CLK         (CLK),
        .nRST        (nRST),
        .issue_valid (issue_valid),
        .issue       (issue),
        .issue_ready (issue_ready),
        .stall       (stall),
        .ex_valid    (ex_valid),
        .ex          (ex)
    );

    // both units work on the execute register in parallel
    bru_target_unit u_target (
        .ex  (ex),
        .tgt (tgt)
    );

    bru_link_unit u_link (
        .ex   (ex),
        .link (link)
    );

    bru_result_stage u_result (
        .CLK         (CLK),
        .nRST        (nRST),
        .ex_valid    (ex_valid),
        .ex          (ex),
        .tgt         (tgt),
        .link        (link),
        .wb_ready    (wb_ready),
        .notif_ready (notif_ready),
        .stall       (stall),
        .wb_valid    (wb_valid),
        .wb          (wb),
        .notif_valid (notif_valid),
        .notif       (notif)
    );

endmodule

/* tb_bru_tasks.svh */
// ----------------------------------------
// reference model, op driver and the
// directed tests
// ----------------------------------------

    // legal offset for the op's immediate format
    function automatic word_t make_offset(input bru_op_e op, input word_t r);
        word_t off;
        case (op)
            OP_JALR:          off = {{20{r[11]}}, r[11:0]};
            OP_LUI, OP_AUIPC: off = {r[31:12], 12'h000};
            OP_JAL, OP_C_JAL, OP_C_J, OP_C_JR, OP_C_JALR: begin
                off = {{11{r[20]}}, r[20:1], 1'b0};
            end
            default:          off = {{19{r[12]}}, r[12:1], 1'b0};    // branches
        endcase
        return off;
    endfunction

    // packs an offset into imm20, unused bits get junk
    function automatic imm20_t encode_imm(input bru_op_e op, input word_t off,
                                          input logic [7:0] junk);
        imm20_t enc;
        case (op)
            OP_JALR:          enc = {junk, off[11:0]};
            OP_LUI, OP_AUIPC: enc = {off[19:12], off[31:20]};
            OP_JAL, OP_C_JAL, OP_C_J, OP_C_JR, OP_C_JALR: begin
                enc = {off[19:12], off[20], off[10:1], off[11]};
            end
            default:          enc = {junk, off[12], off[10:1], off[11]};
        endcase
        return enc;
    endfunction

    function automatic exp_result_t expect_result(input bru_issue_t op, input word_t imm);
        exp_result_t r;
        logic        cond;
        logic        is_c;      // 16-bit encoding
        r    = '0;
        is_c = op.op inside {OP_C_JALR, OP_C_JAL, OP_C_J, OP_C_JR, OP_C_BEQZ, OP_C_BNEZ};
        case (op.op)
            OP_BEQ:    cond = op.a == op.b;
            OP_BNE:    cond = op.a != op.b;
            OP_C_BEQZ: cond = op.a == 32'd0;
            OP_C_BNEZ: cond = op.a != 32'd0;
            // signed order via flipped sign bits
            OP_BLT:    cond = (op.a ^ 32'h8000_0000) < (op.b ^ 32'h8000_0000);
            OP_BGE:    cond = (op.a ^ 32'h8000_0000) >= (op.b ^ 32'h8000_0000);
            OP_BLTU:   cond = op.a < op.b;
            OP_BGEU:   cond = op.a >= op.b;
            default:   cond = 1'b1;
        endcase
        case (op.op)
            OP_JALR:            r.notif.target_pc = op.a + imm;
            OP_C_JALR, OP_C_JR: r.notif.target_pc = op.a;
            default:            r.notif.target_pc = cond ? op.pc + imm : op.pc + 32'd4;
        endcase
        case (op.op)
            OP_C_JALR, OP_C_JAL: r.wb.data = op.pc + 32'd2;
            OP_LUI:              r.wb.data = imm;
            OP_AUIPC:            r.wb.data = op.pc + imm;
            default:             r.wb.data = op.pc + 32'd4;
        endcase
        r.has_wb              = op.op inside {OP_JALR, OP_C_JALR, OP_JAL, OP_C_JAL,
                                              OP_LUI, OP_AUIPC};
        r.has_notif           = !(op.op inside {OP_LUI, OP_AUIPC});
        r.wb.pr               = op.dest_pr;
        r.wb.rob_index        = op.rob_index;
        r.notif.rob_index     = op.rob_index;
        r.notif.is_taken      = cond;
        r.notif.start_pc      = is_c ? op.pc : op.pc + 32'd2;
        r.notif.is_mispredict = r.notif.target_pc != op.pred_pc;
        return r;
    endfunction

    // drives one op until accepted and queues its expected result
    task automatic issue_op(input bru_op_e op, input word_t a, input word_t b,
                            input logic pred_hit);
        bru_issue_t  op_in;
        exp_result_t expected;
        word_t       off;
        word_t       rnd;
        logic        accepted;
        logic [31:0] accept_edge;
        rnd             = $random(seed);
        off             = make_offset(op, rnd);
        rnd             = $random(seed);
        op_in.pc        = {rnd[31:1], 1'b0};
        rnd             = $random(seed);
        op_in.op        = op;
        op_in.imm20     = encode_imm(op, off, rnd[7:0]);
        op_in.a         = a;
        op_in.b         = b;
        op_in.dest_pr   = rnd[14:8];
        op_in.rob_index = rob_cnt;
        op_in.pred_pc   = '0;
        expected        = expect_result(op_in, off);
        op_in.pred_pc   = pred_hit ? expected.notif.target_pc
                                   : expected.notif.target_pc + 32'd4;
        expected        = expect_result(op_in, off);
        rob_cnt         = rob_cnt + 1'b1;

        issue_valid = 1'b1;
        issue       = op_in;
        accepted    = 1'b0;
        accept_edge = '0;
        while (!accepted) begin
            @(negedge CLK);
            accepted    = issue_ready;
            accept_edge = cycle_cnt + 32'd1;
            @(posedge CLK);
        end
        expected.accept_cycle = accept_edge;
        exp_q.push_back(expected);
        #1;
        issue_valid = 1'b0;
    endtask

    task automatic wait_drain();
        while (exp_q.size() != 0) begin
            @(negedge CLK);
        end
        @(posedge CLK);
        #1;
    endtask

    // ----------------------------------------
    // directed tests

    task automatic test_reset();
        @(negedge CLK);
        check_bit("issue_ready", 1'b1, issue_ready);
        check_bit("wb_valid", 1'b0, wb_valid);
        check_bit("notif_valid", 1'b0, notif_valid);
        @(posedge CLK);
        #1;
    endtask

    task automatic test_jumps();
        bru_op_e jump_ops[6] = '{OP_JALR, OP_C_JALR, OP_JAL, OP_C_JAL, OP_C_J, OP_C_JR};
        word_t   a;
        word_t   r;
        for (int k = 0; k < 6; k++) begin
            repeat (3) begin
                a = $random(seed);
                r = $random(seed);
                issue_op(jump_ops[k], a, r, r[0]);
            end
        end
        wait_drain();
    endtask

    task automatic test_branches();
        bru_op_e br_ops[8] = '{OP_BEQ, OP_BNE, OP_C_BEQZ, OP_C_BNEZ,
                               OP_BLT, OP_BGE, OP_BLTU, OP_BGEU};
        word_t   r1;
        word_t   r2;
        word_t   a;
        word_t   b;
        for (int op_k = 0; op_k < 8; op_k++) begin
            for (int k = 0; k < 6; k++) begin
                r1 = $random(seed);
                r2 = $random(seed);
                case (k)
                    0:       {a, b} = {r1, r1};
                    1:       {a, b} = {32'd0, r2};
                    2:       {a, b} = {r1 | 32'h8000_0000, r2 & 32'h7fff_ffff};
                    3:       {a, b} = {r1 & 32'h7fff_ffff, r2 | 32'h8000_0000};
                    4:       {a, b} = {r1 & 32'h0000_ffff, (r1 & 32'h0000_ffff) + 32'd1};
                    default: {a, b} = {r1 | 32'h8000_0000, (r1 | 32'h8000_0000) - 32'd1};
                endcase
                issue_op(br_ops[op_k], a, b, r2[0]);
            end
        end
        wait_drain();
    endtask

    task automatic test_upper_imm();
        word_t a;
        repeat (3) begin
            a = $random(seed);
            issue_op(OP_LUI, a, ~a, a[0]);
            issue_op(OP_AUIPC, ~a, a, a[1]);
        end
        wait_drain();
    endtask

    task automatic test_mispredict();
        word_t  a;
        integer saved;
        a     = $random(seed);
        saved = seed;
        issue_op(OP_BEQ, a, a, 1'b1);      // taken
        seed  = saved;                      // same draws, same pc and imm
        issue_op(OP_BEQ, a, a, 1'b0);
        saved = seed;
        issue_op(OP_BLTU, 32'd9, 32'd3, 1'b1);      // not taken
        seed  = saved;
        issue_op(OP_BLTU, 32'd9, 32'd3, 1'b0);
        wait_drain();
    endtask

    task automatic test_backpressure();
        word_t r;
        word_t a;
        bp_active = 1'b1;
        repeat (40) begin
            r = $random(seed);
            a = r[8] ? 32'd0 : $random(seed);
            issue_op(bru_op_e'(r[3:0]), a, r[4] ? a : a ^ r, r[5]);
            if (r[6]) begin
                @(posedge CLK);     // bubble
                #1;
            end
        end
        wait_drain();
        bp_active = 1'b0;
    endtask

/* tb_bru_pipeline.sv */
// ----------------------------------------
// testbench for the branch resolution
// pipeline: clock, reset, watchdog,
// output monitor and compare tasks
// ----------------------------------------

`timescale 1ns/1ps

module tb_bru_pipeline;

    import bru_pkg::*;

    localparam int NUM_OPS         = 116;
    localparam int WATCHDOG_CYCLES = NUM_OPS * 20 + 200;

    // one expected result, in issue order
    typedef struct packed {
        logic        has_wb;
        bru_wb_t     wb;
        logic        has_notif;
        bru_notif_t  notif;
        logic [31:0] accept_cycle;
    } exp_result_t;

    logic        CLK = 1'b0;
    logic        nRST;
    logic        issue_valid;
    bru_issue_t  issue;
    logic        issue_ready;
    logic        wb_valid;
    bru_wb_t     wb;
    logic        wb_ready;
    logic        notif_valid;
    bru_notif_t  notif;
    logic        notif_ready;

    integer      seed;                  // op stimulus
    integer      ready_seed;            // back-pressure pattern
    logic [31:0] cycle_cnt = '0;
    logic        bp_active;
    logic        check_latency;
    logic        held = 1'b0;           // result seen, not yet taken
    rob_index_t  rob_cnt;
    exp_result_t exp_q[$];

    bru_pipeline uut (
        .CLK         (CLK),
        .nRST        (nRST),
        .issue_valid (issue_valid),
        .issue       (issue),
        .issue_ready (issue_ready),
        .wb_valid    (wb_valid),
        .wb          (wb),
        .wb_ready    (wb_ready),
        .notif_valid (notif_valid),
        .notif       (notif),
        .notif_ready (notif_ready)
    );

    always #50 CLK = ~CLK;

    always @(posedge CLK) begin
        cycle_cnt <= cycle_cnt + 32'd1;
    end

    // ----------------------------------------
    // compare tasks

    task automatic abort_run(input string msg);
        $display("%s", msg);
        $display("Test failed");
        $fatal(1);
    endtask

    task automatic check_bit(input string name, input logic expected, input logic actual);
        if (actual !== expected) begin
            abort_run($sformatf("MISMATCH %s: expected %h, got %h", name, expected, actual));
        end
    endtask

    task automatic check_wb(input string name, input bru_wb_t expected, input bru_wb_t actual);
        if (actual !== expected) begin
            abort_run($sformatf("MISMATCH %s: expected %h, got %h", name, expected, actual));
        end
    endtask

    task automatic check_notif(input string name, input bru_notif_t expected,
                               input bru_notif_t actual);
        if (actual !== expected) begin
            abort_run($sformatf("MISMATCH %s: expected %h, got %h", name, expected, actual));
        end
    endtask

    `include "tb_bru_tasks.svh"

    // ----------------------------------------
    // output monitor, falling edge so all outputs are settled

    always @(negedge CLK) begin
        exp_result_t front;
        logic        taken_now;
        if (nRST) begin
            if (wb_valid || notif_valid) begin
                if (exp_q.size() == 0) begin
                    abort_run("output valid while no op is in flight");
                end
                front = exp_q[0];
                check_bit("wb_valid", front.has_wb, wb_valid);
                check_bit("notif_valid", front.has_notif, notif_valid);
                if (front.has_wb) begin
                    check_wb("wb", front.wb, wb);
                end
                if (front.has_notif) begin
                    check_notif("notif", front.notif, notif);
                end
                if (check_latency && !held && (cycle_cnt - front.accept_cycle != 32'd2)) begin
                    abort_run($sformatf("result for rob index %h came %0d cycles after issue",
                                        front.wb.rob_index, cycle_cnt - front.accept_cycle));
                end
                // leaves at the next edge only if every valid side is ready
                taken_now = (!wb_valid || wb_ready) && (!notif_valid || notif_ready);
                if (taken_now) begin
                    void'(exp_q.pop_front());
                end
                held = !taken_now;
            end else if (held) begin
                abort_run("result vanished while its sink was stalled");
            end
        end
    end

    // ready pattern, random stretches while back-pressure is on
    initial begin
        word_t      rnd;
        logic [2:0] wb_left;
        logic [2:0] notif_left;
        wb_ready    = 1'b1;
        notif_ready = 1'b1;
        wb_left     = '0;
        notif_left  = '0;
        forever begin
            @(posedge CLK);
            #1;
            rnd = $random(ready_seed);
            if (!bp_active) begin
                wb_ready    = 1'b1;
                notif_ready = 1'b1;
            end else begin
                if (wb_left == 3'd0) begin
                    wb_ready = rnd[3];
                    wb_left  = rnd[2:0];
                end else begin
                    wb_left = wb_left - 3'd1;
                end
                if (notif_left == 3'd0) begin
                    notif_ready = rnd[7];
                    notif_left  = rnd[6:4];
                end else begin
                    notif_left = notif_left - 3'd1;
                end
            end
        end
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge CLK);
        abort_run($sformatf("timeout after %0d cycles with %0d results missing",
                            WATCHDOG_CYCLES, exp_q.size()));
    end

    // ----------------------------------------
    // test sequence

    initial begin
        seed          = 32'he849fcb0;
        ready_seed    = 32'he849fcb0;
        nRST          = 1'b0;
        issue_valid   = 1'b0;
        issue         = '0;
        bp_active     = 1'b0;
        check_latency = 1'b0;
        rob_cnt       = '0;
        repeat (10) @(posedge CLK);
        #1;
        nRST = 1'b1;

        test_reset();
        check_latency = 1'b1;   // no stalls in these, latency is exact
        test_jumps();
        test_branches();
        test_upper_imm();
        test_mispredict();
        check_latency = 1'b0;
        test_backpressure();

        $display("Test completed successfully");
        $finish;
    end

endmodule

/* vlog.f */
+incdir+.
bru_pkg.sv
bru_decode_stage.sv
bru_target_unit.sv
bru_link_unit.sv
bru_result_stage.sv
bru_pipeline.sv
tb_bru_pipeline.sv

/* run.sh */
#!/bin/sh
# build with verilator, run, and look for the pass line
verilator --binary --timing --timescale 1ns/1ps --top-module tb_bru_pipeline \
    -f vlog.f -o tb_bru_pipeline \
    && ./obj_dir/tb_bru_pipeline | tee /dev/stderr | grep -q "Test completed successfully" \
    && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }
